// ==== hw/hdr_pkg.sv ====
// shared widths, register addresses, mode codes, preambles, FSM and path enums, parity function
`default_nettype none

package hdr_pkg;

  // I3C mode code, only HDR-DDR permits a restart
  typedef logic [2:0] mode_t;
  localparam mode_t MODE_HDR_DDR = 3'd6;

  // register file addressing
  typedef logic [11:0] regf_addr_t;
  localparam regf_addr_t REGF_ADDR_CMD   = 12'd1000;
  localparam regf_addr_t REGF_ADDR_DUMMY = 12'd450;
  localparam int         REGF_DEPTH      = 1024;
  localparam int         REGF_IDX_W      = 10;

  // payload and frame
  typedef logic [15:0] hdr_word_t;
  typedef logic [19:0] frame_bits_t;
  typedef logic [4:0]  bit_cnt_t;
  typedef logic [3:0]  word_cnt_t;

  localparam logic [1:0] PRE_CCC    = 2'b01;
  localparam logic [1:0] PRE_DDR    = 2'b10;
  localparam bit_cnt_t   FRAME_LAST = 5'd19;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CCC,
    ST_DDR
  } engine_state_t;

  typedef enum logic {
    PATH_DDR = 1'b0,
    PATH_CCC = 1'b1
  } path_sel_t;

  // high bit covers odd-index bits, low bit is the inverted even-index parity
  function automatic logic [1:0] hdr_parity(input hdr_word_t word);
    return {^(word & 16'hAAAA), ~(^(word & 16'h5555))};
  endfunction

endpackage

`default_nettype wire

// ==== hw/hdr_frame_if.sv ====
// frame generator to path multiplexer interface
`default_nettype none
`timescale 1ns/1ps

interface hdr_frame_if;

  // register file read request
  logic                regf_rd_en;
  hdr_pkg::regf_addr_t regf_addr;

  // serial stream, sda_bit is only meaningful with sda_valid
  logic                sda_bit;
  logic                sda_valid;

  modport gen (
    output regf_rd_en,
    output regf_addr,
    output sda_bit,
    output sda_valid
  );

  modport mux (
    input regf_rd_en,
    input regf_addr,
    input sda_bit,
    input sda_valid
  );

endinterface

`default_nettype wire

// ==== hw/hdr_regfile.sv ====
// register file, 1024 words by 16 bits, one write port and one synchronous read port
`default_nettype none
`timescale 1ns/1ps

module hdr_regfile (
  input  logic                i_sys_clk,
  input  logic                i_sys_rst_n,
  input  logic                i_wr_en,
  input  hdr_pkg::regf_addr_t i_wr_addr,
  input  hdr_pkg::hdr_word_t  i_wr_data,
  input  logic                i_rd_en,
  input  hdr_pkg::regf_addr_t i_rd_addr,
  output hdr_pkg::hdr_word_t  o_rd_data
);

  hdr_pkg::hdr_word_t mem [hdr_pkg::REGF_DEPTH];

  // storage array, loaded from the top level write port
  always_ff @(posedge i_sys_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr[hdr_pkg::REGF_IDX_W-1:0]] <= i_wr_data;
    end
  end

  // read data lands one cycle after the request
  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_rd_data <= '0;
    end else if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr[hdr_pkg::REGF_IDX_W-1:0]];
    end
  end

endmodule

`default_nettype wire

// ==== hw/hdr_engine.sv ====
// HDR command engine FSM with configuration capture, restart and abort handling
`default_nettype none
`timescale 1ns/1ps

module hdr_engine (
  input  logic                i_sys_clk,
  input  logic                i_sys_rst_n,
  input  logic                i_engine_en,
  input  logic                i_cmd_cp,
  input  logic                i_cmd_toc,
  input  hdr_pkg::mode_t      i_cmd_mode,
  input  logic                i_ccc_done,
  input  logic                i_ddr_done,
  output logic                o_ccc_en,
  output hdr_pkg::regf_addr_t o_ccc_addr,
  output logic                o_ddr_en,
  output hdr_pkg::path_sel_t  o_path_sel,
  output logic                o_engine_done
);

  hdr_pkg::engine_state_t state_q;
  logic                   cfg_cp_q;
  logic                   cfg_toc_q;
  hdr_pkg::mode_t         cfg_mode_q;
  // launch_q marks the cycle with enables low before a frame starts
  logic                   launch_q;
  // set while the dummy CCC frame ahead of DDR is in flight
  logic                   dummy_q;
  logic                   end_now;

  // no restart unless toc is clear and the mode is HDR-DDR
  assign end_now = cfg_toc_q | (cfg_mode_q != hdr_pkg::MODE_HDR_DDR);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      state_q       <= hdr_pkg::ST_IDLE;
      cfg_cp_q      <= 1'b0;
      cfg_toc_q     <= 1'b0;
      cfg_mode_q    <= '0;
      launch_q      <= 1'b0;
      dummy_q       <= 1'b0;
      o_ccc_en      <= 1'b0;
      o_ccc_addr    <= hdr_pkg::REGF_ADDR_CMD;
      o_ddr_en      <= 1'b0;
      o_path_sel    <= hdr_pkg::PATH_DDR;
      o_engine_done <= 1'b0;
    end else begin
      o_engine_done <= 1'b0;
      launch_q      <= 1'b0;
      if (!i_engine_en) begin
        // abort, frames in flight are dropped without done
        state_q  <= hdr_pkg::ST_IDLE;
        o_ccc_en <= 1'b0;
        o_ddr_en <= 1'b0;
        dummy_q  <= 1'b0;
      end else if (launch_q) begin
        if (dummy_q) begin
          state_q    <= hdr_pkg::ST_CCC;
          o_ccc_en   <= 1'b1;
          o_ccc_addr <= hdr_pkg::REGF_ADDR_DUMMY;
          o_path_sel <= hdr_pkg::PATH_CCC;
        end else if (cfg_cp_q) begin
          state_q    <= hdr_pkg::ST_CCC;
          o_ccc_en   <= 1'b1;
          o_ccc_addr <= hdr_pkg::REGF_ADDR_CMD;
          o_path_sel <= hdr_pkg::PATH_CCC;
        end else begin
          state_q    <= hdr_pkg::ST_DDR;
          o_ddr_en   <= 1'b1;
          o_path_sel <= hdr_pkg::PATH_DDR;
        end
      end else begin
        unique case (state_q)
          hdr_pkg::ST_IDLE: begin
            cfg_cp_q   <= i_cmd_cp;
            cfg_toc_q  <= i_cmd_toc;
            cfg_mode_q <= i_cmd_mode;
            launch_q   <= 1'b1;
          end
          hdr_pkg::ST_CCC: begin
            if (i_ccc_done) begin
              o_ccc_en <= 1'b0;
              if (dummy_q) begin
                // dummy frame done, captured cp is 0 so the launch picks DDR
                dummy_q  <= 1'b0;
                launch_q <= 1'b1;
              end else if (end_now) begin
                o_engine_done <= 1'b1;
                state_q       <= hdr_pkg::ST_IDLE;
              end else begin
                cfg_cp_q   <= i_cmd_cp;
                cfg_toc_q  <= i_cmd_toc;
                cfg_mode_q <= i_cmd_mode;
                dummy_q    <= ~i_cmd_cp;
                launch_q   <= 1'b1;
              end
            end
          end
          hdr_pkg::ST_DDR: begin
            if (i_ddr_done) begin
              o_ddr_en <= 1'b0;
              if (end_now) begin
                o_engine_done <= 1'b1;
                state_q       <= hdr_pkg::ST_IDLE;
              end else begin
                cfg_cp_q   <= i_cmd_cp;
                cfg_toc_q  <= i_cmd_toc;
                cfg_mode_q <= i_cmd_mode;
                launch_q   <= 1'b1;
              end
            end
          end
          default: begin
            state_q <= hdr_pkg::ST_IDLE;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/ccc_frame_gen.sv ====
// CCC frame generator, one command word fetched and serialized per enable
`default_nettype none
`timescale 1ns/1ps

module ccc_frame_gen (
  input  logic                i_sys_clk,
  input  logic                i_sys_rst_n,
  input  logic                i_en,
  input  hdr_pkg::regf_addr_t i_addr,
  input  hdr_pkg::hdr_word_t  i_rd_data,
  output logic                o_done,
  hdr_frame_if.gen            frame
);

  logic                 en_q;
  logic                 en_rise;
  logic                 rd_en_q;
  logic                 rd_pend_q;
  logic                 valid_q;
  logic                 done_q;
  hdr_pkg::bit_cnt_t    bit_cnt_q;
  hdr_pkg::frame_bits_t shift_q;
  hdr_pkg::regf_addr_t  addr_q;

  assign en_rise = i_en & ~en_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      en_q      <= 1'b0;
      rd_en_q   <= 1'b0;
      rd_pend_q <= 1'b0;
      valid_q   <= 1'b0;
      done_q    <= 1'b0;
      bit_cnt_q <= '0;
      shift_q   <= '0;
    end else begin
      en_q      <= i_en;
      rd_en_q   <= 1'b0;
      done_q    <= 1'b0;
      rd_pend_q <= rd_en_q;
      if (!i_en) begin
        // enable dropped, give up the current frame
        rd_pend_q <= 1'b0;
        valid_q   <= 1'b0;
        bit_cnt_q <= '0;
      end else if (en_rise) begin
        rd_en_q <= 1'b1;
      end else if (rd_pend_q) begin
        shift_q   <= {hdr_pkg::PRE_CCC, i_rd_data, hdr_pkg::hdr_parity(i_rd_data)};
        valid_q   <= 1'b1;
        bit_cnt_q <= '0;
      end else if (valid_q) begin
        shift_q <= shift_q << 1;
        if (bit_cnt_q == hdr_pkg::FRAME_LAST) begin
          valid_q <= 1'b0;
          done_q  <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + 5'd1;
        end
      end
    end
  end

  // address held for the whole frame
  always_ff @(posedge i_sys_clk) begin
    if (en_rise) begin
      addr_q <= i_addr;
    end
  end

  assign frame.regf_rd_en = rd_en_q;
  assign frame.regf_addr  = addr_q;
  assign frame.sda_bit    = shift_q[19];
  assign frame.sda_valid  = valid_q;
  assign o_done           = done_q;

endmodule

`default_nettype wire

// ==== hw/ddr_frame_gen.sv ====
// DDR frame generator, a counted run of words from address 0, each serialized as a frame
`default_nettype none
`timescale 1ns/1ps

module ddr_frame_gen (
  input  logic                i_sys_clk,
  input  logic                i_sys_rst_n,
  input  logic                i_en,
  input  hdr_pkg::word_cnt_t  i_word_cnt,
  input  hdr_pkg::hdr_word_t  i_rd_data,
  output logic                o_done,
  hdr_frame_if.gen            frame
);

  logic                 en_q;
  logic                 en_rise;
  logic                 rd_en_q;
  logic                 rd_pend_q;
  logic                 valid_q;
  logic                 done_q;
  logic                 last_word;
  hdr_pkg::bit_cnt_t    bit_cnt_q;
  hdr_pkg::word_cnt_t   word_q;
  hdr_pkg::word_cnt_t   cnt_q;
  hdr_pkg::frame_bits_t shift_q;

  assign en_rise   = i_en & ~en_q;
  assign last_word = ((word_q + 4'd1) == cnt_q);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      en_q      <= 1'b0;
      rd_en_q   <= 1'b0;
      rd_pend_q <= 1'b0;
      valid_q   <= 1'b0;
      done_q    <= 1'b0;
      bit_cnt_q <= '0;
      word_q    <= '0;
      shift_q   <= '0;
    end else begin
      en_q      <= i_en;
      rd_en_q   <= 1'b0;
      done_q    <= 1'b0;
      rd_pend_q <= rd_en_q;
      if (!i_en) begin
        rd_pend_q <= 1'b0;
        valid_q   <= 1'b0;
        bit_cnt_q <= '0;
        word_q    <= '0;
      end else if (en_rise) begin
        // every run starts again at address 0
        word_q  <= '0;
        rd_en_q <= 1'b1;
      end else if (rd_pend_q) begin
        shift_q   <= {hdr_pkg::PRE_DDR, i_rd_data, hdr_pkg::hdr_parity(i_rd_data)};
        valid_q   <= 1'b1;
        bit_cnt_q <= '0;
      end else if (valid_q) begin
        shift_q <= shift_q << 1;
        if (bit_cnt_q == hdr_pkg::FRAME_LAST) begin
          valid_q   <= 1'b0;
          bit_cnt_q <= '0;
          if (last_word) begin
            done_q <= 1'b1;
          end else begin
            // next fetch, leaves a two cycle gap on the wire
            word_q  <= word_q + 4'd1;
            rd_en_q <= 1'b1;
          end
        end else begin
          bit_cnt_q <= bit_cnt_q + 5'd1;
        end
      end
    end
  end

  // word count sampled at the start of the run
  always_ff @(posedge i_sys_clk) begin
    if (en_rise) begin
      cnt_q <= i_word_cnt;
    end
  end

  assign frame.regf_rd_en = rd_en_q;
  assign frame.regf_addr  = hdr_pkg::regf_addr_t'(word_q);
  assign frame.sda_bit    = shift_q[19];
  assign frame.sda_valid  = valid_q;
  assign o_done           = done_q;

endmodule

`default_nettype wire

// ==== hw/hdr_path_mux.sv ====
// path multiplexer for the register file read port and the registered serial output
`default_nettype none
`timescale 1ns/1ps

module hdr_path_mux (
  input  logic                i_sys_clk,
  input  logic                i_sys_rst_n,
  input  hdr_pkg::path_sel_t  i_path_sel,
  hdr_frame_if.mux            ccc,
  hdr_frame_if.mux            ddr,
  output logic                o_rd_en,
  output hdr_pkg::regf_addr_t o_rd_addr,
  output logic                o_sda,
  output logic                o_sda_valid
);

  // read request goes straight through to the register file
  always_comb begin
    if (i_path_sel == hdr_pkg::PATH_CCC) begin
      o_rd_en   = ccc.regf_rd_en;
      o_rd_addr = ccc.regf_addr;
    end else begin
      o_rd_en   = ddr.regf_rd_en;
      o_rd_addr = ddr.regf_addr;
    end
  end

  // one register stage on the serial side
  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_sda       <= 1'b0;
      o_sda_valid <= 1'b0;
    end else if (i_path_sel == hdr_pkg::PATH_CCC) begin
      o_sda       <= ccc.sda_bit;
      o_sda_valid <= ccc.sda_valid;
    end else begin
      o_sda       <= ddr.sda_bit;
      o_sda_valid <= ddr.sda_valid;
    end
  end

endmodule

`default_nettype wire

// ==== hw/i3c_hdr_top.sv ====
// top level of the HDR slice, engine, frame generators, path multiplexer and register file
`default_nettype none
`timescale 1ns/1ps

module i3c_hdr_top (
  input  logic                i_sys_clk,
  input  logic                i_sys_rst_n,
  input  logic                i_engine_en,
  input  logic                i_cmd_cp,
  input  logic                i_cmd_toc,
  input  hdr_pkg::mode_t      i_cmd_mode,
  input  hdr_pkg::word_cnt_t  i_ddr_words,
  input  logic                i_regf_wr_en,
  input  hdr_pkg::regf_addr_t i_regf_wr_addr,
  input  hdr_pkg::hdr_word_t  i_regf_wr_data,
  output logic                o_sda,
  output logic                o_sda_valid,
  output hdr_pkg::path_sel_t  o_path_sel,
  output logic                o_engine_done
);

  logic                ccc_en;
  logic                ddr_en;
  logic                ccc_done;
  logic                ddr_done;
  logic                regf_rd_en;
  hdr_pkg::regf_addr_t ccc_addr;
  hdr_pkg::regf_addr_t regf_rd_addr;
  hdr_pkg::hdr_word_t  regf_rd_data;

  hdr_frame_if ccc_frame ();
  hdr_frame_if ddr_frame ();

  hdr_regfile u_regfile (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_wr_en     (i_regf_wr_en),
    .i_wr_addr   (i_regf_wr_addr),
    .i_wr_data   (i_regf_wr_data),
    .i_rd_en     (regf_rd_en),
    .i_rd_addr   (regf_rd_addr),
    .o_rd_data   (regf_rd_data)
  );

  hdr_engine u_engine (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst_n   (i_sys_rst_n),
    .i_engine_en   (i_engine_en),
    .i_cmd_cp      (i_cmd_cp),
    .i_cmd_toc     (i_cmd_toc),
    .i_cmd_mode    (i_cmd_mode),
    .i_ccc_done    (ccc_done),
    .i_ddr_done    (ddr_done),
    .o_ccc_en      (ccc_en),
    .o_ccc_addr    (ccc_addr),
    .o_ddr_en      (ddr_en),
    .o_path_sel    (o_path_sel),
    .o_engine_done (o_engine_done)
  );

  ccc_frame_gen u_ccc_gen (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_en        (ccc_en),
    .i_addr      (ccc_addr),
    .i_rd_data   (regf_rd_data),
    .o_done      (ccc_done),
    .frame       (ccc_frame)
  );

  ddr_frame_gen u_ddr_gen (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_en        (ddr_en),
    .i_word_cnt  (i_ddr_words),
    .i_rd_data   (regf_rd_data),
    .o_done      (ddr_done),
    .frame       (ddr_frame)
  );

  hdr_path_mux u_path_mux (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_path_sel  (o_path_sel),
    .ccc         (ccc_frame),
    .ddr         (ddr_frame),
    .o_rd_en     (regf_rd_en),
    .o_rd_addr   (regf_rd_addr),
    .o_sda       (o_sda),
    .o_sda_valid (o_sda_valid)
  );

endmodule

`default_nettype wire

// ==== verif/hdr_properties.sv ====
// bound concurrent assertions on the HDR top level outputs
`default_nettype none
`timescale 1ns/1ps

module hdr_properties (
  input logic               i_sys_clk,
  input logic               i_sys_rst_n,
  input logic               i_engine_en,
  input logic               i_sda,
  input logic               i_sda_valid,
  input hdr_pkg::path_sel_t i_path_sel,
  input logic               i_engine_done
);

  // engine done is a single cycle pulse
  a_done_single: assert property (
    @(posedge i_sys_clk) disable iff (!i_sys_rst_n)
      i_engine_done |=> !i_engine_done
  ) else $error("engine done held high for more than one cycle");

  // enable low long enough to flush the generator and the output register
  a_quiet_when_disabled: assert property (
    @(posedge i_sys_clk) disable iff (!i_sys_rst_n)
      (!i_engine_en && !$past(i_engine_en) && !$past(i_engine_en, 2)) |=> !i_sda_valid
  ) else $error("serial valid seen with the engine disabled");

  // path select never moves under a running frame
  a_path_steady: assert property (
    @(posedge i_sys_clk) disable iff (!i_sys_rst_n)
      i_sda_valid |-> $stable(i_path_sel)
  ) else $error("path select changed while serial valid was high");

  a_outputs_known: assert property (
    @(posedge i_sys_clk) disable iff (!i_sys_rst_n)
      !$isunknown({i_sda, i_sda_valid, i_path_sel, i_engine_done})
  ) else $error("unknown value on a top level output");

endmodule

bind i3c_hdr_top hdr_properties u_hdr_properties (
  .i_sys_clk     (i_sys_clk),
  .i_sys_rst_n   (i_sys_rst_n),
  .i_engine_en   (i_engine_en),
  .i_sda         (o_sda),
  .i_sda_valid   (o_sda_valid),
  .i_path_sel    (o_path_sel),
  .i_engine_done (o_engine_done)
);

`default_nettype wire

// ==== verif/tb_i3c_hdr_top.sv ====
// testbench for the HDR slice with clock, reset, register loading, scenarios, frame checks
`default_nettype none
`timescale 1ns/1ps

module tb_i3c_hdr_top;

  localparam int          CLK_HALF        = 20;
  localparam int          DRIVE_DELAY     = 2;
  localparam logic [31:0] SEED            = 32'h3571;
  localparam int          TOTAL_FRAMES    = 17;
  localparam int          FRAME_CYCLES    = 30;
  localparam int          WATCHDOG_CYCLES = TOTAL_FRAMES * FRAME_CYCLES + 600;

  logic                i_sys_clk;
  logic                i_sys_rst_n;
  logic                i_engine_en;
  logic                i_cmd_cp;
  logic                i_cmd_toc;
  hdr_pkg::mode_t      i_cmd_mode;
  hdr_pkg::word_cnt_t  i_ddr_words;
  logic                i_regf_wr_en;
  hdr_pkg::regf_addr_t i_regf_wr_addr;
  hdr_pkg::hdr_word_t  i_regf_wr_data;
  logic                o_sda;
  logic                o_sda_valid;
  hdr_pkg::path_sel_t  o_path_sel;
  logic                o_engine_done;

  // copy of every word written to the register file
  hdr_pkg::hdr_word_t   shadow [int];
  hdr_pkg::frame_bits_t exp_frames [$];
  hdr_pkg::path_sel_t   exp_paths [$];
  hdr_pkg::frame_bits_t cap_bits;
  int                   bit_count;
  int                   frames_seen;
  logic                 done_allowed;
  logic [31:0]          rnd;

  i3c_hdr_top DUT (.*);

  initial begin
    i_sys_clk = 1'b0;
    forever #CLK_HALF i_sys_clk = ~i_sys_clk;
  end

  function automatic hdr_pkg::frame_bits_t build_frame(input logic [1:0] pre,
                                                       input hdr_pkg::hdr_word_t word);
    return {pre, word, hdr_pkg::hdr_parity(word)};
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic next_cycle();
    @(posedge i_sys_clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_idle();
    assert (o_sda_valid == 1'b0)
      else report_failure($sformatf("mismatch o_sda_valid: got 0x%0h expected 0x0", o_sda_valid));
    assert (o_engine_done == 1'b0)
      else report_failure($sformatf("mismatch o_engine_done: got 0x%0h expected 0x0",
                                    o_engine_done));
    assert (o_path_sel == hdr_pkg::PATH_DDR)
      else report_failure($sformatf("mismatch o_path_sel: got 0x%0h expected 0x0", o_path_sel));
  endtask

  task automatic load_word(input int addr);
    rnd = $urandom();
    shadow[addr] = rnd[15:0];
    i_regf_wr_en   = 1'b1;
    i_regf_wr_addr = hdr_pkg::regf_addr_t'(addr);
    i_regf_wr_data = rnd[15:0];
    next_cycle();
    i_regf_wr_en = 1'b0;
    check_idle();
  endtask

  task automatic expect_ccc(input int addr);
    exp_frames.push_back(build_frame(hdr_pkg::PRE_CCC, shadow[addr]));
    exp_paths.push_back(hdr_pkg::PATH_CCC);
  endtask

  // a DDR run always reads from address 0 upward
  task automatic expect_ddr_run(input int words);
    for (int i = 0; i < words; i++) begin
      exp_frames.push_back(build_frame(hdr_pkg::PRE_DDR, shadow[i]));
      exp_paths.push_back(hdr_pkg::PATH_DDR);
    end
  endtask

  task automatic start_transfer(input logic cp, input logic toc, input hdr_pkg::mode_t mode,
                                input int words);
    i_cmd_cp    = cp;
    i_cmd_toc   = toc;
    i_cmd_mode  = mode;
    i_ddr_words = hdr_pkg::word_cnt_t'(words);
    i_engine_en = 1'b1;
    next_cycle();
  endtask

  task automatic wait_frames(input int target);
    int waited;
    waited = 0;
    while (frames_seen < target && waited < 2 * FRAME_CYCLES) begin
      next_cycle();
      waited++;
    end
    assert (frames_seen >= target)
      else report_failure("an expected frame did not appear on the serial output");
  endtask

  task automatic wait_serial_start();
    int waited;
    waited = 0;
    while (!o_sda_valid && waited < 10) begin
      next_cycle();
      waited++;
    end
    assert (o_sda_valid) else report_failure("serial output never started after a start");
  endtask

  // enable drops right after done so the engine stays idle
  task automatic wait_done(input int frames);
    int waited;
    waited = 0;
    done_allowed = 1'b1;
    while (!o_engine_done && waited < frames * FRAME_CYCLES + 20) begin
      next_cycle();
      waited++;
    end
    assert (o_engine_done) else report_failure("engine done missing at the end of a transfer");
    assert (exp_frames.size() == 0)
      else report_failure("engine done came before all expected frames were sent");
    i_engine_en = 1'b0;
    next_cycle();
    done_allowed = 1'b0;
  endtask

  // frame capture on the falling edge, away from the registered output updates
  always @(negedge i_sys_clk) begin
    if (!i_sys_rst_n || !o_sda_valid) begin
      bit_count = 0;
    end else begin
      if (bit_count == 0) begin
        assert (exp_frames.size() > 0)
          else report_failure("a serial frame started while none was expected");
      end
      assert (o_path_sel == exp_paths[0])
        else report_failure($sformatf("mismatch o_path_sel: got 0x%0h expected 0x%0h",
                                      o_path_sel, exp_paths[0]));
      cap_bits = {cap_bits[18:0], o_sda};
      bit_count++;
      if (bit_count == 20) begin
        assert (cap_bits == exp_frames[0])
          else report_failure($sformatf("mismatch o_sda frame: got 0x%05h expected 0x%05h",
                                        cap_bits, exp_frames[0]));
        void'(exp_frames.pop_front());
        void'(exp_paths.pop_front());
        frames_seen++;
        bit_count = 0;
      end
    end
  end

  always @(negedge i_sys_clk) begin
    if (i_sys_rst_n && o_engine_done) begin
      assert (done_allowed)
        else report_failure("engine done pulsed outside an expected transfer end");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_sys_clk);
    report_failure("watchdog expired before the scenarios finished");
  end

  initial begin
    int base;
    i_sys_rst_n    = 1'b0;
    i_engine_en    = 1'b0;
    i_cmd_cp       = 1'b0;
    i_cmd_toc      = 1'b0;
    i_cmd_mode     = '0;
    i_ddr_words    = '0;
    i_regf_wr_en   = 1'b0;
    i_regf_wr_addr = '0;
    i_regf_wr_data = '0;
    done_allowed   = 1'b0;
    frames_seen    = 0;
    bit_count      = 0;
    cap_bits       = '0;
    rnd            = $urandom(SEED);
    repeat (4) @(posedge i_sys_clk);
    #DRIVE_DELAY;
    i_sys_rst_n = 1'b1;

    // outputs stay quiet through the whole load
    for (int addr = 0; addr < 16; addr++) begin
      load_word(addr);
    end
    load_word(int'(hdr_pkg::REGF_ADDR_DUMMY));
    load_word(int'(hdr_pkg::REGF_ADDR_CMD));

    // single CCC frame
    expect_ccc(int'(hdr_pkg::REGF_ADDR_CMD));
    start_transfer(1'b1, 1'b1, hdr_pkg::MODE_HDR_DDR, 0);
    wait_done(1);

    // DDR run ended by toc, then by a mode without restart
    expect_ddr_run(3);
    start_transfer(1'b0, 1'b1, hdr_pkg::MODE_HDR_DDR, 3);
    wait_done(3);
    expect_ddr_run(3);
    start_transfer(1'b0, 1'b0, 3'd2, 3);
    wait_done(3);

    // CCC, dummy CCC, DDR, then a DDR restart that picks up toc
    base = frames_seen;
    expect_ccc(int'(hdr_pkg::REGF_ADDR_CMD));
    expect_ccc(int'(hdr_pkg::REGF_ADDR_DUMMY));
    expect_ddr_run(2);
    expect_ddr_run(2);
    start_transfer(1'b1, 1'b0, hdr_pkg::MODE_HDR_DDR, 2);
    repeat (3) next_cycle();
    i_cmd_cp = 1'b0;
    wait_frames(base + 1);
    i_cmd_toc = 1'b1;
    wait_done(5);

    // DDR restarting into CCC
    expect_ddr_run(2);
    expect_ccc(int'(hdr_pkg::REGF_ADDR_CMD));
    start_transfer(1'b0, 1'b0, hdr_pkg::MODE_HDR_DDR, 2);
    repeat (3) next_cycle();
    i_cmd_cp  = 1'b1;
    i_cmd_toc = 1'b1;
    wait_done(3);

    // abort in the middle of a DDR frame
    base = frames_seen;
    expect_ddr_run(3);
    start_transfer(1'b0, 1'b1, hdr_pkg::MODE_HDR_DDR, 3);
    wait_serial_start();
    repeat (6) next_cycle();
    i_engine_en = 1'b0;
    repeat (FRAME_CYCLES) next_cycle();
    assert (o_sda_valid == 1'b0)
      else report_failure($sformatf("mismatch o_sda_valid: got 0x%0h expected 0x0", o_sda_valid));
    assert (frames_seen == base)
      else report_failure("a frame completed after the transfer was aborted");
    exp_frames.delete();
    exp_paths.delete();
    expect_ccc(int'(hdr_pkg::REGF_ADDR_CMD));
    start_transfer(1'b1, 1'b1, hdr_pkg::MODE_HDR_DDR, 0);
    wait_done(1);

    repeat (4) next_cycle();
    if (exp_frames.size() == 0 && frames_seen == TOTAL_FRAMES) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      report_failure("number of frames seen does not match the scenarios");
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/hdr_pkg.sv
hw/hdr_frame_if.sv
hw/hdr_regfile.sv
hw/hdr_engine.sv
hw/ccc_frame_gen.sv
hw/ddr_frame_gen.sv
hw/hdr_path_mux.sv
hw/i3c_hdr_top.sv
verif/hdr_properties.sv
verif/tb_i3c_hdr_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the HDR slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_i3c_hdr_top -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_i3c_hdr_top > sim.log 2>&1
status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
